/* Bender.yml */
package:
  name: status_monitor

export_include_dirs:
  - .

sources:
  - xfer_status_pkg.sv
  - xfer_bus_pkg.sv
  - status_xfer.sv
  - status_write_arbiter.sv
  - status_bank.sv
  - status_monitor_top.sv
  - target: test
    files:
      - tb_status_monitor.sv

/* all.f */
+incdir+.
xfer_status_pkg.sv
xfer_bus_pkg.sv
status_xfer.sv
status_write_arbiter.sv
status_bank.sv
status_monitor_top.sv
tb_status_monitor.sv

/* status_bank.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module status_bank import xfer_status_pkg::*, xfer_bus_pkg::*; (
  input  logic      up_clk,
  input  logic      up_rst,
  input  logic      wr_en,
  input  chan_idx_t wr_addr,
  input  status_t   wr_data,
  input  logic      up_rreq,
  input  chan_idx_t up_raddr,
  output logic      up_rack,
  output status_t   up_rdata
);

  status_t bank_q [`XFER_NUM_CHAN];

  //////////////////////////////
  // Snapshot registers
  //////////////////////////////

  // Entries must read zero until the first snapshot arrives
  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      for (int i = 0; i < `XFER_NUM_CHAN; i++) begin
        bank_q[i] <= '0;
      end
    end else if (wr_en) begin
      bank_q[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      up_rack <= 1'b0;
    end else begin
      up_rack <= up_rreq; // One cycle after the strobe
    end
  end

  // Samples before this cycle's write lands, so a colliding read sees the old value
  always_ff @(posedge up_clk) begin
    if (up_rreq) begin
      up_rdata <= bank_q[up_raddr];
    end
  end

endmodule

/* status_monitor_top.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module status_monitor_top import xfer_status_pkg::*, xfer_bus_pkg::*; (
  input  logic      d_clk,
  input  logic      d_rst,
  input  logic      up_clk,
  input  logic      up_rst,
  input  status_t   d_status0,
  input  status_t   d_status1,
  input  status_t   d_status2,
  input  status_t   d_status3,
  input  logic      up_rreq,
  input  chan_idx_t up_raddr,
  output logic      up_rack,
  output status_t   up_rdata
);

  status_t    d_status_arr  [`XFER_NUM_CHAN];
  status_t    up_status_arr [`XFER_NUM_CHAN];
  chan_mask_t up_update;
  logic       wr_en;
  chan_idx_t  wr_addr;
  status_t    wr_data;

  assign d_status_arr[0] = d_status0;
  assign d_status_arr[1] = d_status1;
  assign d_status_arr[2] = d_status2;
  assign d_status_arr[3] = d_status3;

  //////////////////////////////
  // Per-channel transfer
  //////////////////////////////

  for (genvar ch = 0; ch < `XFER_NUM_CHAN; ch++) begin : g_chan
    status_xfer xfer (
      .d_clk     (d_clk),
      .d_rst     (d_rst),
      .up_clk    (up_clk),
      .up_rst    (up_rst),
      .d_status  (d_status_arr[ch]),
      .up_status (up_status_arr[ch]),
      .up_update (up_update[ch])
    );
  end

  //////////////////////////////
  // Shared write port and bank
  //////////////////////////////

  status_write_arbiter arb0 (
    .up_clk     (up_clk),
    .up_rst     (up_rst),
    .up_update  (up_update),
    .up_status0 (up_status_arr[0]),
    .up_status1 (up_status_arr[1]),
    .up_status2 (up_status_arr[2]),
    .up_status3 (up_status_arr[3]),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  // Processor reads go straight to the bank
  status_bank bank0 (
    .up_clk   (up_clk),
    .up_rst   (up_rst),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rack  (up_rack),
    .up_rdata (up_rdata)
  );

endmodule

/* status_write_arbiter.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module status_write_arbiter import xfer_status_pkg::*, xfer_bus_pkg::*; (
  input  logic       up_clk,
  input  logic       up_rst,
  input  chan_mask_t up_update,
  input  status_t    up_status0,
  input  status_t    up_status1,
  input  status_t    up_status2,
  input  status_t    up_status3,
  output logic       wr_en,
  output chan_idx_t  wr_addr,
  output status_t    wr_data
);

  status_t    status_arr [`XFER_NUM_CHAN];
  chan_mask_t pending;
  chan_mask_t grant_clr;
  chan_idx_t  last_grant;
  chan_idx_t  pick;
  logic       pick_vld;
  arb_state_t state;

  assign status_arr[0] = up_status0;
  assign status_arr[1] = up_status1;
  assign status_arr[2] = up_status2;
  assign status_arr[3] = up_status3;

  //////////////////////////////
  // Round-robin selection
  //////////////////////////////

  // Search starts one past the channel granted last
  always_comb begin
    chan_idx_t cand;
    pick     = last_grant;
    pick_vld = 1'b0;
    for (int i = 1; i <= `XFER_NUM_CHAN; i++) begin
      cand = last_grant + chan_idx_t'(i);
      if (!pick_vld && pending[cand]) begin
        pick     = cand;
        pick_vld = 1'b1;
      end
    end
  end

  assign grant_clr = pick_vld ? (chan_mask_t'(1) << pick) : '0;

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      pending    <= '0;
      last_grant <= '0;
      state      <= ARB_IDLE;
    end else begin
      // A new strobe wins over the clear, so the later snapshot gets written too
      pending <= (pending & ~grant_clr) | up_update;
      if (pick_vld) begin
        last_grant <= pick;
        state      <= ARB_GRANT;
      end else begin
        state      <= ARB_IDLE;
      end
    end
  end

  assign wr_en = (state == ARB_GRANT);

  always_ff @(posedge up_clk) begin
    if (pick_vld) begin
      wr_addr <= pick;
      wr_data <= status_arr[pick]; // Latest snapshot of that channel
    end
  end

endmodule

/* status_xfer.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module status_xfer import xfer_status_pkg::*; (
  input  logic    d_clk,
  input  logic    d_rst,
  input  logic    up_clk,
  input  logic    up_rst,
  input  status_t d_status,
  output status_t up_status,
  output logic    up_update
);

  localparam int SYNC_N = `XFER_SYNC_STAGES;

  window_cnt_t             d_count;
  logic                    d_toggle;
  logic [SYNC_N-1:0]       d_ack_sync;
  logic                    d_busy;
  logic                    d_xfer;
  status_t                 d_acc;
  status_t                 d_hold;

  logic [SYNC_N-1:0]       up_sync;
  logic                    up_edge;

  //////////////////////////////
  // Converter clock domain
  //////////////////////////////

  // The toggle is back from the up side once both copies agree
  assign d_busy = d_ack_sync[SYNC_N-1] ^ d_toggle;
  assign d_xfer = (d_count == WINDOW_XFER_POS) && !d_busy;

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      d_count    <= '0;
      d_toggle   <= 1'b0;
      d_ack_sync <= '0;
      d_acc      <= '0;
    end else begin
      d_count    <= d_count + window_cnt_t'(1);
      d_ack_sync <= {d_ack_sync[SYNC_N-2:0], up_sync[SYNC_N-1]};
      if (d_xfer) begin
        d_toggle <= ~d_toggle;
        d_acc    <= d_status; // Current input opens the next window
      end else begin
        d_acc    <= d_acc | d_status;
      end
    end
  end

  // Stays put until the up side has taken it, the toggle protects it
  always_ff @(posedge d_clk) begin
    if (d_xfer) begin
      d_hold <= d_acc;
    end
  end

  //////////////////////////////
  // Processor clock domain
  //////////////////////////////

  // A change between the last two flops marks a fresh snapshot
  assign up_edge = up_sync[SYNC_N-1] ^ up_sync[SYNC_N-2];

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      up_sync   <= '0;
      up_update <= 1'b0;
      up_status <= '0;
    end else begin
      up_sync   <= {up_sync[SYNC_N-2:0], d_toggle};
      up_update <= up_edge;
      if (up_edge) begin
        up_status <= d_hold;
      end
    end
  end

endmodule

/* tb_status_monitor.sv */
`timescale 1ns/1ps
`include "xfer_config.svh"

module tb_status_monitor import xfer_status_pkg::*, xfer_bus_pkg::*;;

  localparam int NCH         = `XFER_NUM_CHAN;
  localparam int D_PERIOD    = 20;
  localparam int N_FIXED     = 8;
  localparam int N_RAND      = 12;
  localparam int N_ROWS      = N_FIXED + N_RAND;
  localparam int HOLD_CYCLES = 300; // d_clk cycles a value or a trailing zero is held
  localparam int POLL_CYCLES = 400; // Bound for a pulse to reach the bank
  localparam int WDOG_CYCLES = N_ROWS * 400 + 2000;

  logic      d_clk = 1'b0;
  logic      up_clk = 1'b0;
  logic      d_rst;
  logic      up_rst;
  status_t   d_status [NCH];
  logic      up_rreq;
  chan_idx_t up_raddr;
  logic      up_rack;
  status_t   up_rdata;

  status_t     tbl_val [N_ROWS][NCH];
  logic        tbl_pulse [N_ROWS];
  status_t     tbl_exp [N_ROWS][NCH];
  status_t     rd_vals [NCH];
  logic [31:0] rng_state = 32'd57887;
  longint      d_cycles = 0;

  always #10 d_clk = ~d_clk;
  always #13 up_clk = ~up_clk; // Unrelated to d_clk on purpose

  always @(posedge d_clk) d_cycles <= d_cycles + 1;

  status_monitor_top dut0 (
    .d_clk     (d_clk),
    .d_rst     (d_rst),
    .up_clk    (up_clk),
    .up_rst    (up_rst),
    .d_status0 (d_status[0]),
    .d_status1 (d_status[1]),
    .d_status2 (d_status[2]),
    .d_status3 (d_status[3]),
    .up_rreq   (up_rreq),
    .up_raddr  (up_raddr),
    .up_rack   (up_rack),
    .up_rdata  (up_rdata)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic set_row(input int r, input logic pulse, input status_t v0, input status_t v1,
                         input status_t v2, input status_t v3);
    tbl_pulse[r] = pulse;
    tbl_val[r][0] = v0;
    tbl_val[r][1] = v1;
    tbl_val[r][2] = v2;
    tbl_val[r][3] = v3;
    // Each row expects its own applied values back
    for (int c = 0; c < NCH; c++) tbl_exp[r][c] = tbl_val[r][c];
  endtask

  task automatic fill_table();
    status_t v [NCH];
    set_row(0, 1'b1, 8'h00, 8'h5a, 8'h00, 8'h00);
    set_row(1, 1'b1, 8'h00, 8'h00, 8'h00, 8'h81);
    set_row(2, 1'b0, 8'h11, 8'h22, 8'h44, 8'h88);
    set_row(3, 1'b0, 8'hff, 8'h00, 8'ha5, 8'h3c);
    set_row(4, 1'b0, 8'h00, 8'h00, 8'h00, 8'h00); // Clears the bank before the next pulses
    set_row(5, 1'b1, 8'h01, 8'h00, 8'h00, 8'h00);
    set_row(6, 1'b1, 8'h00, 8'h00, 8'hf0, 8'h00);
    set_row(7, 1'b0, 8'h0f, 8'hf0, 8'h55, 8'haa);
    for (int r = N_FIXED; r < N_ROWS; r++) begin
      for (int c = 0; c < NCH; c++) begin
        rng_state = xorshift32(rng_state);
        v[c] = rng_state[15:8];
      end
      set_row(r, 1'b0, v[0], v[1], v[2], v[3]);
    end
  endtask

  task automatic read_one(input int ch, output status_t val);
    @(posedge up_clk);
    #2;
    up_rreq  = 1'b1;
    up_raddr = chan_idx_t'(ch);
    @(posedge up_clk);
    #2;
    val     = up_rdata;
    up_rreq = 1'b0;
  endtask

  // Reads all channels back to back with one strobe per cycle
  task automatic read_all();
    @(posedge up_clk);
    #2;
    up_rreq  = 1'b1;
    up_raddr = chan_idx_t'(0);
    for (int i = 1; i <= NCH; i++) begin
      @(posedge up_clk);
      #2;
      rd_vals[i-1] = up_rdata;
      if (i < NCH) up_raddr = chan_idx_t'(i);
      else up_rreq = 1'b0;
    end
  endtask

  task automatic check_all(input int r, input logic use_zero);
    status_t exp;
    read_all();
    for (int c = 0; c < NCH; c++) begin
      exp = use_zero ? status_t'(0) : tbl_exp[r][c];
      check_val($sformatf("up_rdata ch%0d row %0d", c, r), rd_vals[c], exp);
    end
  endtask

  // Keeps reading until the pulse shows up or the deadline passes
  task automatic poll_chan(input int r, input int ch, input longint deadline);
    status_t got;
    read_one(ch, got);
    while (got !== tbl_exp[r][ch] && d_cycles < deadline) read_one(ch, got);
    check_val($sformatf("up_rdata ch%0d row %0d (pulse)", ch, r), got, tbl_exp[r][ch]);
  endtask

  //////////////////////////////
  // Read acknowledge monitor
  //////////////////////////////

  // Just after the edge up_rreq still holds what the DUT sampled there
  always @(posedge up_clk) begin
    #1;
    if (up_rst === 1'b0) check_val("up_rack", up_rack, up_rreq);
  end

  initial begin
    #(WDOG_CYCLES * D_PERIOD);
    $display("Timeout: the run did not finish within %0d d_clk cycles", WDOG_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    longint start;
    d_rst    = 1'b1;
    up_rst   = 1'b1;
    up_rreq  = 1'b0;
    up_raddr = '0;
    for (int c = 0; c < NCH; c++) d_status[c] = '0;
    fill_table();

    fork
      begin
        repeat (2) @(posedge d_clk);
        #2 d_rst = 1'b0;
      end
      begin
        repeat (2) @(posedge up_clk);
        #2 up_rst = 1'b0;
      end
    join

    repeat (4) @(posedge up_clk);
    check_all(0, 1'b1); // Bank is empty out of reset

    for (int r = 0; r < N_ROWS; r++) begin
      @(posedge d_clk);
      #2;
      for (int c = 0; c < NCH; c++) d_status[c] = tbl_val[r][c];
      start = d_cycles;
      if (tbl_pulse[r]) begin
        @(posedge d_clk);
        #2;
        for (int c = 0; c < NCH; c++) d_status[c] = '0;
        for (int c = 0; c < NCH; c++) poll_chan(r, c, start + POLL_CYCLES);
        while (d_cycles < start + HOLD_CYCLES) @(posedge d_clk);
        check_all(r, 1'b1);
      end else begin
        repeat (HOLD_CYCLES) @(posedge d_clk);
        check_all(r, 1'b0);
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* xfer_bus_pkg.sv */
`include "xfer_config.svh"

//////////////////////////////
// Processor side bank types
//////////////////////////////

package xfer_bus_pkg;

  // Channel index, doubles as the bank address
  typedef logic [$clog2(`XFER_NUM_CHAN)-1:0] chan_idx_t;

  typedef logic [`XFER_NUM_CHAN-1:0] chan_mask_t; // One bit per channel

  // Arbiter FSM, GRANT means a bank write is on the port this cycle
  typedef enum logic {
    ARB_IDLE  = 1'b0,
    ARB_GRANT = 1'b1
  } arb_state_t;

endpackage

/* xfer_config.svh */
`ifndef XFER_CONFIG_SVH
`define XFER_CONFIG_SVH

//////////////////////////////
// Channel count and widths
//////////////////////////////

// Number of converter channels sharing the status bank
`define XFER_NUM_CHAN 4

`define XFER_STATUS_WIDTH 8 // Flag bits per channel

// Window counter width, the window is 2**bits d_clk cycles
`define XFER_WINDOW_BITS 6

// Flops in each synchronizer
`define XFER_SYNC_STAGES 3

`endif

/* xfer_status_pkg.sv */
`include "xfer_config.svh"

//////////////////////////////
// Converter side status types
//////////////////////////////

package xfer_status_pkg;

  // One channel's flag vector, bits are sticky within a window
  typedef logic [`XFER_STATUS_WIDTH-1:0] status_t;

  typedef logic [`XFER_WINDOW_BITS-1:0] window_cnt_t; // Free-running window position

  // Window position where a finished window is handed over
  localparam window_cnt_t WINDOW_XFER_POS = window_cnt_t'(1);

endpackage
